/* Bender.yml */
package:
  name: core_dpath

sources:
  - hw/dpath_pkg.sv
  - hw/fetch_stage.sv
  - hw/regfile.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/memory_stage.sv
  - hw/core_dpath.sv
  - target: test
    files:
      - tb/tb_core_dpath.sv

/* flist.f */
hw/dpath_pkg.sv
hw/fetch_stage.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_dpath.sv
tb/tb_core_dpath.sv

/* hw/core_dpath.sv */
/* Five-stage RISC-V integer datapath
   Chains fetch, decode, execute and memory stages around the register file */

`default_nettype none

module core_dpath (
  input  wire logic                            clk,
  input  wire logic                            reset,
  input  wire logic                            stall_f,
  input  wire logic                            stall_d,
  input  wire logic                            stall_x,
  input  wire logic                            stall_m,
  input  wire logic                            stall_w,
  input  wire logic [dpath_pkg::PC_SEL_W-1:0]   pc_mux_sel,
  input  wire logic [dpath_pkg::XLEN-1:0]       inst_d,
  input  wire logic [dpath_pkg::OP0_SEL_W-1:0]  op0_sel,
  input  wire logic [dpath_pkg::OP1_SEL_W-1:0]  op1_sel,
  input  wire logic [dpath_pkg::ALU_FN_W-1:0]   alu_fn,
  input  wire logic [dpath_pkg::XLEN-1:0]       dmemresp_msg_data,
  input  wire logic [dpath_pkg::DMM_SEL_W-1:0]  dmemresp_sel,
  input  wire logic                            wb_sel,
  input  wire logic                            rf_wen_w,
  input  wire logic [dpath_pkg::REG_ADDR_W-1:0] rf_waddr_w,
  output logic      [dpath_pkg::XLEN-1:0]       imemreq_msg_addr,
  output logic      [dpath_pkg::XLEN-1:0]       dmemreq_msg_addr,
  output logic      [dpath_pkg::XLEN-1:0]       dmemreq_msg_data,
  output logic                                 branch_cond_eq_x,
  output logic                                 branch_cond_ne_x,
  output logic                                 branch_cond_lt_x,
  output logic                                 branch_cond_ltu_x,
  output logic                                 branch_cond_ge_x,
  output logic                                 branch_cond_geu_x,
  output logic      [dpath_pkg::XLEN-1:0]       proc2csr_data_w
);

  import dpath_pkg::*;

  // Stage-to-stage wires
  logic [XLEN-1:0]       pc_f, pc_plus4_f;
  logic [REG_ADDR_W-1:0] rf_raddr0, rf_raddr1;
  logic [XLEN-1:0]       rf_rdata0, rf_rdata1;
  logic [XLEN-1:0]       op0_x, op1_x, wdata_x, branch_targ_x;
  logic [XLEN-1:0]       execute_m;
  logic [XLEN-1:0]       wb_w;

  fetch_stage u_fetch (
    .clk, .reset, .stall_f, .pc_mux_sel, .branch_targ_x,
    .imemreq_msg_addr, .pc_f, .pc_plus4_f
  );

  decode_stage u_decode (
    .clk, .reset, .stall_d, .stall_x, .pc_f, .pc_plus4_f, .inst_d,
    .op0_sel, .op1_sel, .rf_rdata0, .rf_rdata1,
    .rf_raddr0, .rf_raddr1, .op0_x, .op1_x, .wdata_x, .branch_targ_x
  );

  // Write port driven from writeback and the controller
  regfile u_regfile (
    .clk,
    .raddr0 (rf_raddr0),
    .raddr1 (rf_raddr1),
    .waddr  (rf_waddr_w),
    .wen    (rf_wen_w),
    .wdata  (wb_w),
    .rdata0 (rf_rdata0),
    .rdata1 (rf_rdata1)
  );

  execute_stage u_execute (
    .clk, .reset, .stall_m, .alu_fn, .op0_x, .op1_x, .wdata_x,
    .branch_cond_eq_x, .branch_cond_ne_x, .branch_cond_lt_x,
    .branch_cond_ltu_x, .branch_cond_ge_x, .branch_cond_geu_x,
    .dmemreq_msg_addr, .dmemreq_msg_data, .execute_m
  );

  memory_stage u_memory (
    .clk, .reset, .stall_w, .dmemresp_msg_data, .dmemresp_sel, .wb_sel,
    .execute_m, .wb_w
  );

  assign proc2csr_data_w = wb_w;  // CSR write data

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
/* Decode stage
   Field and immediate decode, operand muxes, branch target, execute registers */

`default_nettype none

module decode_stage (
  input  wire logic                            clk,
  input  wire logic                            reset,
  input  wire logic                            stall_d,
  input  wire logic                            stall_x,
  input  wire logic [dpath_pkg::XLEN-1:0]       pc_f,
  input  wire logic [dpath_pkg::XLEN-1:0]       pc_plus4_f,
  input  wire logic [dpath_pkg::XLEN-1:0]       inst_d,
  input  wire logic [dpath_pkg::OP0_SEL_W-1:0]  op0_sel,
  input  wire logic [dpath_pkg::OP1_SEL_W-1:0]  op1_sel,
  input  wire logic [dpath_pkg::XLEN-1:0]       rf_rdata0,
  input  wire logic [dpath_pkg::XLEN-1:0]       rf_rdata1,
  output logic      [dpath_pkg::REG_ADDR_W-1:0] rf_raddr0,
  output logic      [dpath_pkg::REG_ADDR_W-1:0] rf_raddr1,
  output logic      [dpath_pkg::XLEN-1:0]       op0_x,
  output logic      [dpath_pkg::XLEN-1:0]       op1_x,
  output logic      [dpath_pkg::XLEN-1:0]       wdata_x,
  output logic      [dpath_pkg::XLEN-1:0]       branch_targ_x
);

  import dpath_pkg::*;

  logic [XLEN-1:0] pc_d;        // Decode PC
  logic [XLEN-1:0] pc_plus4_d;
  inst_t           inst;
  logic [XLEN-1:0] shamt;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_sb;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] op0_d;       // Operand mux outputs
  logic [XLEN-1:0] op1_d;

  //--------------------------------------------------------------------------
  // Decode PC registers
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_d       <= '0;
      pc_plus4_d <= '0;
    end else if (!stall_d) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

  //--------------------------------------------------------------------------
  // Field and immediate decode
  //--------------------------------------------------------------------------

  assign inst      = inst_d;
  assign rf_raddr0 = inst.r.rs1;
  assign rf_raddr1 = inst.r.rs2;
  assign shamt     = {{(XLEN-REG_ADDR_W){1'b0}}, inst.r.rs2};  // Zero-extended

  // Sign bit is always inst[31]
  assign imm_i  = {{21{inst.imm.sign}}, inst.imm.hi6, inst.imm.mid4, inst.imm.b20};
  assign imm_s  = {{21{inst.imm.sign}}, inst.imm.hi6, inst.imm.lo4, inst.imm.b7};
  assign imm_sb = {{20{inst.imm.sign}}, inst.imm.b7, inst.imm.hi6, inst.imm.lo4, 1'b0};
  assign imm_u  = {inst.imm.sign, inst.imm.hi6, inst.imm.mid4, inst.imm.b20,
                   inst.imm.b19_12, 12'b0};  // Upper 20 bits

  // Operand muxes
  always_comb begin
    op0_d = '0;
    case (op0_sel)
      AM_RDAT: op0_d = rf_rdata0;
      AM_PC:   op0_d = pc_d;
      AM_PC4:  op0_d = pc_plus4_d;
      AM_0:    op0_d = '0;
    endcase
  end

  always_comb begin
    case (op1_sel)
      BM_RDAT:   op1_d = rf_rdata1;
      BM_SHAMT:  op1_d = shamt;
      BM_IMM_U:  op1_d = imm_u;
      BM_IMM_SB: op1_d = imm_sb;
      BM_IMM_I:  op1_d = imm_i;
      BM_IMM_S:  op1_d = imm_s;
      BM_0:      op1_d = '0;
      default:   op1_d = '0;  // Code 7 unused
    endcase
  end

  //--------------------------------------------------------------------------
  // Execute registers
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      op0_x         <= '0;
      op1_x         <= '0;
      wdata_x       <= '0;
      branch_targ_x <= '0;
    end else if (!stall_x) begin
      op0_x         <= op0_d;
      op1_x         <= op1_d;
      wdata_x       <= rf_rdata1;      // Store data is rs2
      branch_targ_x <= pc_d + imm_sb;  // Single register stage to fetch
    end
  end

endmodule

`default_nettype wire

/* hw/dpath_pkg.sv */
/* Five-stage RISC-V datapath definitions
   Widths, reset vector, select and function codes, instruction word views */

`default_nettype none

package dpath_pkg;

  localparam int XLEN       = 32;  // Data word
  localparam int REG_ADDR_W = 5;   // Register specifier

  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0008_0000;

  // PC mux select
  localparam int PC_SEL_W = 2;
  localparam logic [PC_SEL_W-1:0] PM_P = 2'd0;  // PC+4
  localparam logic [PC_SEL_W-1:0] PM_B = 2'd1;  // Branch target

  // Operand 0 mux select
  localparam int OP0_SEL_W = 2;
  localparam logic [OP0_SEL_W-1:0] AM_RDAT = 2'd0;  // rs1 data
  localparam logic [OP0_SEL_W-1:0] AM_PC   = 2'd1;  // Decode PC
  localparam logic [OP0_SEL_W-1:0] AM_PC4  = 2'd2;  // Decode PC+4
  localparam logic [OP0_SEL_W-1:0] AM_0    = 2'd3;  // Constant 0

  // Operand 1 mux select
  localparam int OP1_SEL_W = 3;
  localparam logic [OP1_SEL_W-1:0] BM_RDAT   = 3'd0;  // rs2 data
  localparam logic [OP1_SEL_W-1:0] BM_SHAMT  = 3'd1;  // Zero-extended shift amount
  localparam logic [OP1_SEL_W-1:0] BM_IMM_U  = 3'd2;
  localparam logic [OP1_SEL_W-1:0] BM_IMM_SB = 3'd3;
  localparam logic [OP1_SEL_W-1:0] BM_IMM_I  = 3'd4;
  localparam logic [OP1_SEL_W-1:0] BM_IMM_S  = 3'd5;
  localparam logic [OP1_SEL_W-1:0] BM_0      = 3'd6;  // Constant 0

  // ALU function
  localparam int ALU_FN_W = 4;
  localparam logic [ALU_FN_W-1:0] ALU_ADD = 4'd0;
  localparam logic [ALU_FN_W-1:0] ALU_SUB = 4'd1;
  localparam logic [ALU_FN_W-1:0] ALU_SLL = 4'd2;
  localparam logic [ALU_FN_W-1:0] ALU_OR  = 4'd3;
  localparam logic [ALU_FN_W-1:0] ALU_LT  = 4'd4;   // Signed set-less-than
  localparam logic [ALU_FN_W-1:0] ALU_LTU = 4'd5;   // Unsigned set-less-than
  localparam logic [ALU_FN_W-1:0] ALU_AND = 4'd6;
  localparam logic [ALU_FN_W-1:0] ALU_XOR = 4'd7;
  localparam logic [ALU_FN_W-1:0] ALU_NOR = 4'd8;
  localparam logic [ALU_FN_W-1:0] ALU_SRL = 4'd9;
  localparam logic [ALU_FN_W-1:0] ALU_SRA = 4'd10;

  // Load extension select
  localparam int DMM_SEL_W = 3;
  localparam logic [DMM_SEL_W-1:0] DMM_W  = 3'd0;  // Full word
  localparam logic [DMM_SEL_W-1:0] DMM_B  = 3'd1;  // Byte, sign-extended
  localparam logic [DMM_SEL_W-1:0] DMM_BU = 3'd2;  // Byte, zero-extended
  localparam logic [DMM_SEL_W-1:0] DMM_H  = 3'd3;  // Halfword, sign-extended
  localparam logic [DMM_SEL_W-1:0] DMM_HU = 3'd4;  // Halfword, zero-extended

  // Writeback select
  localparam logic WM_ALU = 1'b0;
  localparam logic WM_MEM = 1'b1;

  // One instruction word, two decodings
  typedef union packed {
    struct packed {        // Register view
      logic [6:0] funct7;
      logic [4:0] rs2;     // Doubles as shamt
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {        // Immediate bit groups
      logic       sign;    // inst[31]
      logic [5:0] hi6;     // inst[30:25]
      logic [3:0] mid4;    // inst[24:21]
      logic       b20;     // inst[20]
      logic [7:0] b19_12;  // inst[19:12]
      logic [3:0] lo4;     // inst[11:8]
      logic       b7;      // inst[7]
      logic [6:0] opcode;
    } imm;
  } inst_t;

endpackage

`default_nettype wire

/* hw/execute_stage.sv */
/* Execute stage
   ALU, branch condition flags, data-memory request and memory-stage register */

`default_nettype none

module execute_stage (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          stall_m,
  input  wire logic [dpath_pkg::ALU_FN_W-1:0] alu_fn,
  input  wire logic [dpath_pkg::XLEN-1:0]     op0_x,
  input  wire logic [dpath_pkg::XLEN-1:0]     op1_x,
  input  wire logic [dpath_pkg::XLEN-1:0]     wdata_x,
  output logic                               branch_cond_eq_x,
  output logic                               branch_cond_ne_x,
  output logic                               branch_cond_lt_x,
  output logic                               branch_cond_ltu_x,
  output logic                               branch_cond_ge_x,
  output logic                               branch_cond_geu_x,
  output logic      [dpath_pkg::XLEN-1:0]     dmemreq_msg_addr,
  output logic      [dpath_pkg::XLEN-1:0]     dmemreq_msg_data,
  output logic      [dpath_pkg::XLEN-1:0]     execute_m
);

  import dpath_pkg::*;

  logic [4:0]      shamt;    // Low bits of operand 1
  logic [XLEN-1:0] alu_out;

  //--------------------------------------------------------------------------
  // ALU
  //--------------------------------------------------------------------------

  assign shamt = op1_x[4:0];

  always_comb begin
    case (alu_fn)
      ALU_ADD: alu_out = op0_x + op1_x;
      ALU_SUB: alu_out = op0_x - op1_x;
      ALU_SLL: alu_out = op0_x << shamt;
      ALU_OR:  alu_out = op0_x | op1_x;
      ALU_LT:  alu_out = {{(XLEN-1){1'b0}}, $signed(op0_x) < $signed(op1_x)};
      ALU_LTU: alu_out = {{(XLEN-1){1'b0}}, op0_x < op1_x};
      ALU_AND: alu_out = op0_x & op1_x;
      ALU_XOR: alu_out = op0_x ^ op1_x;
      ALU_NOR: alu_out = ~(op0_x | op1_x);
      ALU_SRL: alu_out = op0_x >> shamt;
      ALU_SRA: alu_out = $unsigned($signed(op0_x) >>> shamt);  // Sign fill
      default: alu_out = '0;
    endcase
  end

  // Branch conditions back to the controller
  assign branch_cond_eq_x  = (op0_x == op1_x);
  assign branch_cond_ne_x  = (op0_x != op1_x);
  assign branch_cond_lt_x  = ($signed(op0_x) <  $signed(op1_x));
  assign branch_cond_ltu_x = (op0_x <  op1_x);
  assign branch_cond_ge_x  = ($signed(op0_x) >= $signed(op1_x));
  assign branch_cond_geu_x = (op0_x >= op1_x);

  // Memory request leaves in X, response returns in M
  assign dmemreq_msg_addr = alu_out;  // Effective address
  assign dmemreq_msg_data = wdata_x;

  //--------------------------------------------------------------------------
  // Memory-stage register
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      execute_m <= '0;
    end else if (!stall_m) begin
      execute_m <= alu_out;
    end
  end

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
/* Fetch stage
   Next-PC mux, fetch PC register and instruction-memory address */

`default_nettype none

module fetch_stage (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          stall_f,
  input  wire logic [dpath_pkg::PC_SEL_W-1:0] pc_mux_sel,
  input  wire logic [dpath_pkg::XLEN-1:0]     branch_targ_x,  // From execute registers
  output logic      [dpath_pkg::XLEN-1:0]     imemreq_msg_addr,
  output logic      [dpath_pkg::XLEN-1:0]     pc_f,
  output logic      [dpath_pkg::XLEN-1:0]     pc_plus4_f
);

  import dpath_pkg::*;

  logic [XLEN-1:0] pc_mux_out;  // Next PC

  //--------------------------------------------------------------------------
  // PC select
  //--------------------------------------------------------------------------

  always_comb begin
    case (pc_mux_sel)
      PM_P:    pc_mux_out = pc_plus4_f;
      PM_B:    pc_mux_out = branch_targ_x;
      default: pc_mux_out = RESET_VECTOR;  // Unused codes restart
    endcase
  end

  // Request goes out in the select cycle
  assign imemreq_msg_addr = reset ? RESET_VECTOR : pc_mux_out;

  //--------------------------------------------------------------------------
  // Fetch PC
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f <= pc_mux_out;
    end
  end

  assign pc_plus4_f = pc_f + XLEN'(4);  // Sequential successor

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
/* Memory stage
   Load extension, writeback select and writeback register */

`default_nettype none

module memory_stage (
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  wire logic                           stall_w,
  input  wire logic [dpath_pkg::XLEN-1:0]      dmemresp_msg_data,
  input  wire logic [dpath_pkg::DMM_SEL_W-1:0] dmemresp_sel,
  input  wire logic                           wb_sel,
  input  wire logic [dpath_pkg::XLEN-1:0]      execute_m,
  output logic      [dpath_pkg::XLEN-1:0]      wb_w
);

  import dpath_pkg::*;

  logic [XLEN-1:0] load_data;  // Extended response
  logic [XLEN-1:0] wb_m;

  // Subword data sits in the low bits
  always_comb begin
    case (dmemresp_sel)
      DMM_W:   load_data = dmemresp_msg_data;
      DMM_B:   load_data = {{24{dmemresp_msg_data[7]}}, dmemresp_msg_data[7:0]};
      DMM_BU:  load_data = {24'b0, dmemresp_msg_data[7:0]};
      DMM_H:   load_data = {{16{dmemresp_msg_data[15]}}, dmemresp_msg_data[15:0]};
      DMM_HU:  load_data = {16'b0, dmemresp_msg_data[15:0]};
      default: load_data = '0;
    endcase
  end

  assign wb_m = (wb_sel == WM_MEM) ? load_data : execute_m;

  //--------------------------------------------------------------------------
  // Writeback register
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_w <= '0;
    end else if (!stall_w) begin
      wb_w <= wb_m;  // Feeds regfile and CSR data
    end
  end

endmodule

`default_nettype wire

/* hw/regfile.sv */
/* Integer register file
   Two combinational reads, one clocked write, x0 reads zero */

`default_nettype none

module regfile (
  input  wire logic                            clk,
  input  wire logic [dpath_pkg::REG_ADDR_W-1:0] raddr0,
  input  wire logic [dpath_pkg::REG_ADDR_W-1:0] raddr1,
  input  wire logic [dpath_pkg::REG_ADDR_W-1:0] waddr,
  input  wire logic                            wen,
  input  wire logic [dpath_pkg::XLEN-1:0]       wdata,
  output logic      [dpath_pkg::XLEN-1:0]       rdata0,
  output logic      [dpath_pkg::XLEN-1:0]       rdata1
);

  import dpath_pkg::*;

  logic [XLEN-1:0] regs [2**REG_ADDR_W];  // No reset on the array

  // Write at end of writeback cycle
  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;  // x0 may be written, never read back
    end
  end

  // No bypass from the write port
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

`default_nettype wire

/* tb/tb_core_dpath.sv */
/* Testbench for the five-stage datapath
   Reference pipeline model, concurrent checks on every output, LFSR stimulus */

`default_nettype none

module tb_core_dpath;

  timeunit 1ns;
  timeprecision 1ps;

  import dpath_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 2;
  localparam int PC_CYCLES     = 16;   // Sequential fetch with stalls
  localparam int INIT_CYCLES   = 33;   // One write per register, plus drain
  localparam int STALL_CYCLES  = 8;
  localparam int RANDOM_CYCLES = 400;
  localparam int WATCHDOG_CYCLES =
    RESET_CYCLES + PC_CYCLES + INIT_CYCLES + STALL_CYCLES + RANDOM_CYCLES + 100;

  logic clk, reset;
  logic stall_f, stall_d, stall_x, stall_m, stall_w;
  logic [PC_SEL_W-1:0]   pc_mux_sel;
  logic [XLEN-1:0]       inst_d, dmemresp_msg_data;
  logic [OP0_SEL_W-1:0]  op0_sel;
  logic [OP1_SEL_W-1:0]  op1_sel;
  logic [ALU_FN_W-1:0]   alu_fn;
  logic [DMM_SEL_W-1:0]  dmemresp_sel;
  logic                  wb_sel, rf_wen_w;
  logic [REG_ADDR_W-1:0] rf_waddr_w;
  logic [XLEN-1:0]       imemreq_msg_addr, dmemreq_msg_addr, dmemreq_msg_data;
  logic [XLEN-1:0]       proc2csr_data_w;
  logic branch_cond_eq_x, branch_cond_ne_x, branch_cond_lt_x;
  logic branch_cond_ltu_x, branch_cond_ge_x, branch_cond_geu_x;

  logic [15:0] lfsr = 16'd16;  // Seed

  core_dpath dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Reference functions from the ISA encoding
  //--------------------------------------------------------------------------

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};  // One step per bit
    end
    return val;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [3:0] fn, input logic [31:0] a, b);
    case (fn)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_SLL: return a << b[4:0];
      ALU_OR:  return a | b;
      ALU_LT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_LTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_AND: return a & b;
      ALU_XOR: return a ^ b;
      ALU_NOR: return ~(a | b);
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $unsigned($signed(a) >>> b[4:0]);
      default: return '0;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(input logic [2:0] sel, input logic [31:0] d);
    case (sel)
      DMM_W:   return d;
      DMM_B:   return {{24{d[7]}}, d[7:0]};
      DMM_BU:  return {24'b0, d[7:0]};
      DMM_H:   return {{16{d[15]}}, d[15:0]};
      DMM_HU:  return {16'b0, d[15:0]};
      default: return '0;
    endcase
  endfunction

  //--------------------------------------------------------------------------
  // Pipeline model updated at each rising edge
  //--------------------------------------------------------------------------

  logic [31:0] m_regs [32];
  logic [31:0] m_pc_f, m_pc_d, m_pc4_d, m_op0_x, m_op1_x, m_wdata_x, m_targ_x;
  logic [31:0] m_exec_m, m_wb_w;
  logic [31:0] rs1_val, rs2_val, op0_val, op1_val, imm_sb, next_pc;
  logic [31:0] exp_imem, exp_addr, exp_csr;
  logic [5:0]  exp_flags, act_flags;

  assign rs1_val = (inst_d[19:15] == 5'd0) ? '0 : m_regs[inst_d[19:15]];  // x0 is zero
  assign rs2_val = (inst_d[24:20] == 5'd0) ? '0 : m_regs[inst_d[24:20]];
  assign imm_sb  = {{19{inst_d[31]}}, inst_d[31], inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};
  assign op0_val = (op0_sel == AM_RDAT) ? rs1_val :
                   (op0_sel == AM_PC)   ? m_pc_d  :
                   (op0_sel == AM_PC4)  ? m_pc4_d : '0;

  always_comb begin
    case (op1_sel)
      BM_RDAT:   op1_val = rs2_val;
      BM_SHAMT:  op1_val = {27'b0, inst_d[24:20]};
      BM_IMM_U:  op1_val = {inst_d[31:12], 12'b0};
      BM_IMM_SB: op1_val = imm_sb;
      BM_IMM_I:  op1_val = {{20{inst_d[31]}}, inst_d[31:20]};
      BM_IMM_S:  op1_val = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      default:   op1_val = '0;
    endcase
  end

  assign next_pc   = (pc_mux_sel == PM_B) ? m_targ_x : m_pc_f + 32'd4;
  assign exp_imem  = reset ? RESET_VECTOR : next_pc;
  assign exp_addr  = alu_ref(alu_fn, m_op0_x, m_op1_x);
  assign exp_csr   = m_wb_w;
  assign exp_flags = {m_op0_x == m_op1_x, m_op0_x != m_op1_x,
                      $signed(m_op0_x) < $signed(m_op1_x), m_op0_x < m_op1_x,
                      $signed(m_op0_x) >= $signed(m_op1_x), m_op0_x >= m_op1_x};
  assign act_flags = {branch_cond_eq_x, branch_cond_ne_x, branch_cond_lt_x,
                      branch_cond_ltu_x, branch_cond_ge_x, branch_cond_geu_x};

  always @(posedge clk) begin
    if (reset) begin
      m_pc_f <= RESET_VECTOR;
      {m_pc_d, m_pc4_d, m_op0_x, m_op1_x, m_wdata_x, m_targ_x} <= '0;
      {m_exec_m, m_wb_w} <= '0;
    end else begin
      if (!stall_f) m_pc_f <= next_pc;
      if (!stall_d) begin
        m_pc_d  <= m_pc_f;
        m_pc4_d <= m_pc_f + 32'd4;
      end
      if (!stall_x) begin
        m_op0_x   <= op0_val;
        m_op1_x   <= op1_val;
        m_wdata_x <= rs2_val;            // Store data
        m_targ_x  <= m_pc_d + imm_sb;    // Branch target of decode PC
      end
      if (!stall_m) m_exec_m <= exp_addr;
      if (!stall_w) m_wb_w <= (wb_sel == WM_MEM) ? load_ref(dmemresp_sel, dmemresp_msg_data)
                                                 : m_exec_m;
    end
    if (rf_wen_w) m_regs[rf_waddr_w] <= m_wb_w;  // Visible next cycle
  end

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------

  task automatic report_mismatch(input string name, input logic [31:0] exp_v, act_v);
    $display("Fail at %0d ns: %s expected %h, actual %h", $time, name, exp_v, act_v);
    $display("TESTS FAILED");
    $fatal(1, "Output mismatch");
  endtask

  a_imem: assert property (@(posedge clk) imemreq_msg_addr === exp_imem)
    else report_mismatch("imemreq_msg_addr", $sampled(exp_imem), $sampled(imemreq_msg_addr));
  a_addr: assert property (@(posedge clk) disable iff (reset) dmemreq_msg_addr === exp_addr)
    else report_mismatch("dmemreq_msg_addr", $sampled(exp_addr), $sampled(dmemreq_msg_addr));
  a_data: assert property (@(posedge clk) disable iff (reset) dmemreq_msg_data === m_wdata_x)
    else report_mismatch("dmemreq_msg_data", $sampled(m_wdata_x), $sampled(dmemreq_msg_data));
  a_flag: assert property (@(posedge clk) disable iff (reset) act_flags === exp_flags)
    else report_mismatch("branch_cond flags", $sampled(exp_flags), $sampled(act_flags));
  a_csr:  assert property (@(posedge clk) disable iff (reset) proc2csr_data_w === exp_csr)
    else report_mismatch("proc2csr_data_w", $sampled(exp_csr), $sampled(proc2csr_data_w));

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------

  task automatic drive_random();
    logic [2:0] pick;
    pick              = 3'(rand_bits(3));
    inst_d            = rand_bits(32);
    op0_sel           = 2'(rand_bits(2));
    op1_sel           = (pick == 3'd7) ? BM_0 : pick;  // Code 7 unused
    alu_fn            = 4'(rand_bits(4) % 11);
    pc_mux_sel        = rand_bits(1) ? PM_B : PM_P;
    dmemresp_msg_data = rand_bits(32);
    dmemresp_sel      = 3'(rand_bits(3) % 5);
    wb_sel            = rand_bits(1) ? WM_MEM : WM_ALU;
    rf_wen_w          = rand_bits(1);
    rf_waddr_w        = 5'(rand_bits(5));
    stall_f = (rand_bits(3) == 0);  // About one cycle in eight
    stall_d = (rand_bits(3) == 0);
    stall_x = (rand_bits(3) == 0);
    stall_m = (rand_bits(3) == 0);
    stall_w = (rand_bits(3) == 0);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish within the cycle budget");
    $display("TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    reset = 1'b1;
    {stall_f, stall_d, stall_x, stall_m, stall_w} = '0;
    pc_mux_sel = PM_P;
    inst_d     = '0;   // Reads x0 only until registers hold data
    op0_sel    = AM_0;
    op1_sel    = BM_0;
    alu_fn     = ALU_ADD;
    dmemresp_msg_data = '0;
    dmemresp_sel = DMM_W;
    wb_sel     = WM_ALU;
    rf_wen_w   = 1'b0;
    rf_waddr_w = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // Sequential PC with occasional fetch stalls
    repeat (PC_CYCLES) begin
      @(negedge clk);
      stall_f = rand_bits(1);
    end
    stall_f = 1'b0;

    // Fill every register through the load path including x0
    for (int i = 0; i < INIT_CYCLES; i++) begin
      @(negedge clk);
      wb_sel            = WM_MEM;
      dmemresp_msg_data = rand_bits(32);
      rf_wen_w          = (i > 0);
      rf_waddr_w        = 5'(i - 1);  // Value loaded one cycle earlier
    end

    // Held execute stall while decode keeps changing
    for (int k = 0; k < STALL_CYCLES; k++) begin
      @(negedge clk);
      drive_random();
      {stall_f, stall_d, stall_m, stall_w} = '0;
      stall_x = (k < 4);
      alu_fn  = ALU_ADD;  // Held operands then give a held address
    end

    repeat (RANDOM_CYCLES) begin
      @(negedge clk);
      drive_random();
    end

    repeat (3) @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
